//--- src/immu_pkg.sv
package immu_pkg;

    // ********************************************************
    // address and translation types
    // ********************************************************
    typedef logic [63:0]  vaddr_t;
    typedef logic [63:0]  paddr_t;
    typedef logic [127:0] pte_t;
    typedef logic [15:0]  asid_t;
    typedef logic [1:0]   priv_t;
    typedef logic [3:0]   satp_mode_t;

    // vpn of a 4k page, vaddr[38:12]
    typedef logic [26:0]  vpn_t;

    // ********************************************************
    // privilege and satp constants
    // ********************************************************
    localparam priv_t      PRV_M     = 2'd3;
    localparam satp_mode_t SATP_BARE = 4'd0;

    // ********************************************************
    // walker response layout
    // ********************************************************
    // permission bits
    localparam int PTE_X_BIT = 61;
    localparam int PTE_U_BIT = 62;
    localparam int PTE_G_BIT = 63;

    // field start positions
    localparam int PTE_VPN_LSB  = 31;
    localparam int PTE_PPN_LSB  = 68;
    localparam int PTE_ASID_LSB = 112;

    localparam int PAGE_OFFSET_W = 12;

endpackage

//--- src/immu_tlb.sv
`timescale 1ns/10ps

module immu_tlb #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sflush,
    input  immu_pkg::vaddr_t       vaddr,
    input  immu_pkg::asid_t        asid,
    input  logic                   fill,
    input  logic [TLB_ENTRIES-1:0] fill_way,
    input  immu_pkg::pte_t         pte,
    output logic [TLB_ENTRIES-1:0] hit_vec,
    output logic                   hit,
    output immu_pkg::pte_t         hit_pte
);
    import immu_pkg::*;

    pte_t                   entry_q [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] valid_q;
    vpn_t                   lookup_vpn;

    assign lookup_vpn = vaddr[PAGE_OFFSET_W +: $bits(vpn_t)];

    // ********************************************************
    // entry storage and tag compare
    // ********************************************************
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        vpn_t  tag_vpn;
        asid_t tag_asid;
        logic  asid_ok;

        always_ff @(posedge clk) begin
            if (fill && fill_way[i]) begin
                entry_q[i] <= pte;
            end
        end

        // sflush drops every entry at once
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                valid_q[i] <= 1'b0;
            end else if (sflush) begin
                valid_q[i] <= 1'b0;
            end else if (fill && fill_way[i]) begin
                valid_q[i] <= 1'b1;
            end
        end

        assign tag_vpn  = entry_q[i][PTE_VPN_LSB +: $bits(vpn_t)];
        assign tag_asid = entry_q[i][PTE_ASID_LSB +: $bits(asid_t)];

        // global pages ignore the asid
        assign asid_ok = (tag_asid == asid) || entry_q[i][PTE_G_BIT];

        assign hit_vec[i] = valid_q[i] && (tag_vpn == lookup_vpn) && asid_ok;
    end

    assign hit = |hit_vec;

    // ********************************************************
    // hit entry select
    // ********************************************************
    always_comb begin
        hit_pte = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit_pte = hit_pte | ({$bits(pte_t){hit_vec[i]}} & entry_q[i]);
        end
    end

endmodule

//--- src/immu_plru.sv
`timescale 1ns/10ps

module immu_plru #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   touch,
    input  logic [TLB_ENTRIES-1:0] hit_vec,
    input  logic                   fill,
    output logic [TLB_ENTRIES-1:0] victim
);

    localparam int LEVELS = $clog2(TLB_ENTRIES);

    // heap order, node n has children 2n+1 and 2n+2
    logic [TLB_ENTRIES-2:0] tree_q;
    logic [TLB_ENTRIES-2:0] tree_d;
    logic [LEVELS-1:0]      victim_idx;
    logic [LEVELS-1:0]      hit_idx;
    logic [LEVELS-1:0]      upd_idx;

    // follow the tree bits down to a leaf
    always_comb begin
        int node;
        node = 0;
        for (int l = 0; l < LEVELS; l++) begin
            node = 2 * node + 1 + int'(tree_q[node]);
        end
        victim_idx = LEVELS'(node - (TLB_ENTRIES - 1));
    end

    assign victim = TLB_ENTRIES'(1) << victim_idx;

    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (hit_vec[i]) begin
                hit_idx = hit_idx | LEVELS'(i);
            end
        end
    end

    // point every node on the path away from the used leaf
    always_comb begin
        upd_idx = fill ? victim_idx : hit_idx;
        tree_d  = tree_q;
        for (int l = 0; l < LEVELS; l++) begin
            tree_d[(2 ** l) - 1 + int'(upd_idx >> (LEVELS - l))] = ~upd_idx[LEVELS - 1 - l];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tree_q <= '0;
        end else if (touch || fill) begin
            tree_q <= tree_d;
        end
    end

endmodule

//--- src/immu_walk_ctrl.sv
`timescale 1ns/10ps

module immu_walk_ctrl (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           flush,
    input  logic           miss_start,
    input  logic           miss_ready,
    input  logic           pte_valid,
    input  immu_pkg::pte_t pte,
    input  logic           pte_error,
    input  logic           fetch_ready,
    output logic           miss_valid,
    output logic           pte_ready,
    output logic           fill,
    output logic           walk_done,
    output immu_pkg::pte_t walk_pte,
    output logic           walk_error
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQUEST,
        ST_WAIT,
        ST_DONE
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   pte_hs;

    assign pte_hs = pte_valid && pte_ready;

    // ********************************************************
    // miss fsm
    // ********************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss_start) begin
                    state_d = ST_REQUEST;
                end
            end
            ST_REQUEST: begin
                if (miss_ready) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (pte_valid) begin
                    state_d = ST_DONE;
                end
            end
            ST_DONE: begin
                // held until the fetch side takes the request
                if (fetch_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else if (flush) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // leaf and error captured on the response handshake
    always_ff @(posedge clk) begin
        if (pte_hs) begin
            walk_pte   <= pte;
            walk_error <= pte_error;
        end
    end

    assign miss_valid = (state_q == ST_REQUEST);
    assign pte_ready  = (state_q == ST_WAIT);
    assign walk_done  = (state_q == ST_DONE);

    // faulting leaves are not cached
    assign fill = pte_hs && !pte_error;

endmodule

//--- src/immu_resp.sv
`timescale 1ns/10ps

module immu_resp (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  immu_pkg::priv_t      priv,
    input  immu_pkg::satp_mode_t satp_mode,
    input  logic                 fetch_valid,
    input  immu_pkg::vaddr_t     vaddr,
    input  logic                 tlb_hit,
    input  immu_pkg::pte_t       hit_pte,
    input  logic                 walk_done,
    input  immu_pkg::pte_t       walk_pte,
    input  logic                 walk_error,
    input  logic                 paddr_ready,
    output logic                 fetch_ready,
    output logic                 touch,
    output logic                 miss_start,
    output logic                 paddr_valid,
    output immu_pkg::paddr_t     paddr,
    output logic                 paddr_error
);
    import immu_pkg::*;

    localparam int PPN_W = $bits(paddr_t) - 8 - PAGE_OFFSET_W;

    logic   bypass;
    logic   canonical;
    logic   translate;
    logic   out_free;
    pte_t   sel_pte;
    paddr_t paddr_d;
    logic   fault_d;

    assign bypass    = (priv == PRV_M) || (satp_mode == SATP_BARE);
    assign canonical = (vaddr[63:39] == {25{vaddr[38]}});
    assign translate = !bypass && canonical;
    assign out_free  = paddr_ready || !paddr_valid;

    assign fetch_ready = fetch_valid && out_free
                      && (bypass || tlb_hit || !canonical || walk_done);
    assign touch       = fetch_ready && translate && tlb_hit;
    assign miss_start  = fetch_valid && translate && !tlb_hit && !walk_done;

    // a finished walk wins over the refilled entry
    assign sel_pte = walk_done ? walk_pte : hit_pte;

    assign paddr_d = bypass ? vaddr
                   : {8'h0, sel_pte[PTE_PPN_LSB +: PPN_W], vaddr[PAGE_OFFSET_W-1:0]};

    // no execute, s fetching a u page, u fetching an s page, walker error
    assign fault_d = !bypass && (!canonical
                               || !sel_pte[PTE_X_BIT]
                               || (priv[0] == sel_pte[PTE_U_BIT])
                               || (walk_done && walk_error));

    // ********************************************************
    // output register
    // ********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            paddr_valid <= 1'b0;
        end else if (flush) begin
            paddr_valid <= 1'b0;
        end else if (out_free) begin
            paddr_valid <= fetch_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ready) begin
            paddr       <= paddr_d;
            paddr_error <= fault_d;
        end
    end

endmodule

//--- src/immu.sv
`timescale 1ns/10ps

module immu #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  immu_pkg::priv_t      priv,
    input  immu_pkg::satp_mode_t satp_mode,
    input  immu_pkg::asid_t      asid,
    input  logic                 flush,
    input  logic                 sflush,
    input  logic                 fetch_valid,
    input  immu_pkg::vaddr_t     vaddr,
    input  logic                 miss_ready,
    input  logic                 pte_valid,
    input  immu_pkg::pte_t       pte,
    input  logic                 pte_error,
    input  logic                 paddr_ready,
    output logic                 fetch_ready,
    output logic                 miss_valid,
    output immu_pkg::vaddr_t     miss_vaddr,
    output logic                 pte_ready,
    output logic                 paddr_valid,
    output immu_pkg::paddr_t     paddr,
    output logic                 paddr_error
);
    import immu_pkg::*;

    logic [TLB_ENTRIES-1:0] hit_vec;
    logic [TLB_ENTRIES-1:0] victim;
    logic                   tlb_hit;
    pte_t                   hit_pte;
    logic                   touch;
    logic                   fill;
    logic                   miss_start;
    logic                   walk_done;
    pte_t                   walk_pte;
    logic                   walk_error;

    // walker is pointed at the request still waiting at the fetch port
    assign miss_vaddr = vaddr;

    immu_tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_tlb (
        .clk      (clk),
        .rst_n    (rst_n),
        .sflush   (sflush),
        .vaddr    (vaddr),
        .asid     (asid),
        .fill     (fill),
        .fill_way (victim),
        .pte      (pte),
        .hit_vec  (hit_vec),
        .hit      (tlb_hit),
        .hit_pte  (hit_pte)
    );

    immu_plru #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_plru (
        .clk     (clk),
        .rst_n   (rst_n),
        .touch   (touch),
        .hit_vec (hit_vec),
        .fill    (fill),
        .victim  (victim)
    );

    immu_walk_ctrl i_walk_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .miss_start  (miss_start),
        .miss_ready  (miss_ready),
        .pte_valid   (pte_valid),
        .pte         (pte),
        .pte_error   (pte_error),
        .fetch_ready (fetch_ready),
        .miss_valid  (miss_valid),
        .pte_ready   (pte_ready),
        .fill        (fill),
        .walk_done   (walk_done),
        .walk_pte    (walk_pte),
        .walk_error  (walk_error)
    );

    immu_resp i_resp (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .priv        (priv),
        .satp_mode   (satp_mode),
        .fetch_valid (fetch_valid),
        .vaddr       (vaddr),
        .tlb_hit     (tlb_hit),
        .hit_pte     (hit_pte),
        .walk_done   (walk_done),
        .walk_pte    (walk_pte),
        .walk_error  (walk_error),
        .paddr_ready (paddr_ready),
        .fetch_ready (fetch_ready),
        .touch       (touch),
        .miss_start  (miss_start),
        .paddr_valid (paddr_valid),
        .paddr       (paddr),
        .paddr_error (paddr_error)
    );

endmodule

//--- tb/immu_properties.sv
`timescale 1ns/10ps

module immu_properties (
    input logic             clk,
    input logic             rst_n,
    input logic             flush,
    input logic             miss_valid,
    input logic             miss_ready,
    input immu_pkg::vaddr_t miss_vaddr,
    input logic             pte_ready,
    input logic             paddr_valid,
    input logic             paddr_ready,
    input immu_pkg::paddr_t paddr,
    input logic             paddr_error
);

    int unsigned fail_count = 0;

    // ************************************************************
    // handshake stability
    // ************************************************************
    a_paddr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        paddr_valid && !paddr_ready && !flush
        |=> paddr_valid && $stable(paddr) && $stable(paddr_error))
    else begin
        fail_count++;
        $error("paddr or paddr_error changed while the icache stalled");
    end

    a_miss_hold: assert property (@(posedge clk) disable iff (!rst_n)
        miss_valid && !miss_ready && !flush |=> miss_valid && $stable(miss_vaddr))
    else begin
        fail_count++;
        $error("miss request dropped or changed before miss_ready");
    end

    // first edge out of reset
    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !miss_valid && !pte_ready && !paddr_valid)
    else begin
        fail_count++;
        $error("handshake outputs not low after reset");
    end

endmodule

bind immu immu_properties i_immu_properties (.*);

//--- tb/immu_tb.sv
`timescale 1ns/10ps

module immu_tb;
    import immu_pkg::*;

    localparam int          TLB_ENTRIES = 16;
    localparam int          TIMEOUT     = 200;
    localparam logic [43:0] PPN_PATTERN = 44'h5A5_C3C3_0F0F;
    localparam priv_t       PRV_S       = 2'd1;
    localparam priv_t       PRV_U       = 2'd0;
    localparam satp_mode_t  SATP_SV39   = 4'd8;

    logic       clk;
    logic       rst_n;
    priv_t      priv;
    satp_mode_t satp_mode;
    asid_t      asid;
    logic       flush;
    logic       sflush;
    logic       fetch_valid;
    vaddr_t     vaddr;
    logic       miss_ready;
    logic       pte_valid;
    pte_t       pte;
    logic       pte_error;
    logic       paddr_ready;
    logic       fetch_ready;
    logic       miss_valid;
    vaddr_t     miss_vaddr;
    logic       pte_ready;
    logic       paddr_valid;
    paddr_t     paddr;
    logic       paddr_error;

    integer      seed = 27;
    int          value_errors = 0;
    int          miss_errors = 0;
    int          timeouts = 0;
    int          miss_count = 0;
    logic        walk_pending = 1'b0;
    int          walk_delay = 0;
    vaddr_t      walk_vaddr;
    vaddr_t      exp_paddr_q [$];
    logic        exp_err_q [$];

    immu #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) i_immu (
        .*
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic vaddr_t make_vaddr(input vpn_t vpn, input logic [11:0] offset);
        return {{25{vpn[26]}}, vpn, offset};
    endfunction

    // walker leaf, 4k page with G set
    function automatic pte_t build_pte(input vaddr_t va);
        pte_t p;
        vpn_t vpn;
        vpn = va[38:12];
        p = '0;
        p[57:31] = vpn;
        p[61] = !vpn[3];
        p[62] = vpn[4];
        p[63] = 1'b1;
        p[111:68] = {17'b0, vpn} ^ PPN_PATTERN;
        p[127:112] = asid;
        return p;
    endfunction

    // reference model for one fetch under the current priv and satp
    task automatic predict(input vaddr_t va, output paddr_t pa, output logic err);
        vpn_t vpn;
        vpn = va[38:12];
        if (priv == PRV_M || satp_mode == SATP_BARE) begin
            pa = va;
            err = 1'b0;
        end else if (va[63:39] != {25{va[38]}}) begin
            pa = '0;
            err = 1'b1;
        end else begin
            pa = {8'h0, {17'b0, vpn} ^ PPN_PATTERN, va[11:0]};
            err = vpn[3] || vpn[5] || ((priv == PRV_S) ? vpn[4] : !vpn[4]);
        end
    endtask

    // ************************************************************
    // walker model and random stalls
    // ************************************************************
    always @(posedge clk) begin
        if (pte_valid && pte_ready) begin
            walk_pending = 1'b0;
        end
        if (miss_valid && miss_ready) begin
            miss_count++;
            walk_pending = 1'b1;
            walk_vaddr = miss_vaddr;
            walk_delay = {$random(seed)} % 6;
            assert (miss_vaddr === vaddr) else begin
                value_errors++;
                $display("ERROR at %0t: miss_vaddr expected %h got %h", $time, vaddr, miss_vaddr);
            end
        end
    end

    always @(negedge clk) begin
        miss_ready = ({$random(seed)} % 4) != 0;
        paddr_ready = ({$random(seed)} % 4) != 0;
        if (walk_pending && walk_delay == 0) begin
            pte_valid = 1'b1;
            pte = build_pte(walk_vaddr);
            pte_error = walk_vaddr[17];
        end else begin
            pte_valid = 1'b0;
            if (walk_pending) begin
                walk_delay--;
            end
        end
    end

    // icache side compare against the model queue
    always @(posedge clk) begin
        paddr_t exp_pa;
        logic   exp_err;
        if (paddr_valid && paddr_ready) begin
            if (exp_paddr_q.size() == 0) begin
                value_errors++;
                $display("an output was delivered at %0t with no request outstanding", $time);
            end else begin
                exp_pa = exp_paddr_q.pop_front();
                exp_err = exp_err_q.pop_front();
                assert (paddr_error === exp_err) else begin
                    value_errors++;
                    $display("ERROR at %0t: paddr_error expected %b got %b",
                             $time, exp_err, paddr_error);
                end
                assert (exp_err || paddr === exp_pa) else begin
                    value_errors++;
                    $display("ERROR at %0t: paddr expected %h got %h", $time, exp_pa, paddr);
                end
            end
        end
    end

    // expect_miss 0 no walk, 1 one walk, 2 either
    task automatic do_fetch(input vaddr_t va, input int expect_miss);
        int     misses_before;
        int     cycles;
        logic   taken;
        paddr_t pa;
        logic   err;
        @(negedge clk);
        fetch_valid = 1'b1;
        vaddr = va;
        misses_before = miss_count;
        taken = 1'b0;
        cycles = 0;
        while (!taken && cycles < TIMEOUT) begin
            @(posedge clk);
            taken = fetch_ready;
            cycles++;
        end
        if (!taken) begin
            timeouts++;
            $display("fetch of %h was not accepted within %0d cycles", va, TIMEOUT);
        end else begin
            predict(va, pa, err);
            exp_paddr_q.push_back(pa);
            exp_err_q.push_back(err);
            if (expect_miss != 2) begin
                assert ((miss_count - misses_before) == expect_miss) else begin
                    miss_errors++;
                    $display("ERROR at %0t: miss_valid handshakes expected %0d got %0d",
                             $time, expect_miss, miss_count - misses_before);
                end
            end
        end
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    // ************************************************************
    // test sequence
    // ************************************************************
    initial begin
        int cycles;
        rst_n = 1'b0;
        priv = PRV_M;
        satp_mode = SATP_SV39;
        asid = 16'h0011;
        flush = 1'b0;
        sflush = 1'b0;
        fetch_valid = 1'b0;
        vaddr = '0;
        miss_ready = 1'b0;
        pte_valid = 1'b0;
        pte = '0;
        pte_error = 1'b0;
        paddr_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // bypass in machine mode and in bare mode
        do_fetch(64'hDEAD_BEEF_0000_1234, 0);
        do_fetch(64'h0000_0000_8000_0040, 0);
        priv = PRV_S;
        satp_mode = SATP_BARE;
        do_fetch(64'h1234_5678_9ABC_DEF0, 0);

        // miss, then hit at another offset, then hit under another asid
        satp_mode = SATP_SV39;
        do_fetch(make_vaddr(27'h00100, 12'h010), 1);
        do_fetch(make_vaddr(27'h00100, 12'hFF8), 0);
        asid = 16'h0022;
        do_fetch(make_vaddr(27'h00100, 12'h400), 0);

        // no execute, user page from S, supervisor page from U, walker error
        do_fetch(make_vaddr(27'h00208, 12'h000), 1);
        do_fetch(make_vaddr(27'h00310, 12'h004), 1);
        priv = PRV_U;
        do_fetch(make_vaddr(27'h00310, 12'h008), 0);
        do_fetch(make_vaddr(27'h00100, 12'h00C), 0);
        do_fetch(make_vaddr(27'h00430, 12'h100), 1);
        priv = PRV_S;

        // non-canonical never walks
        do_fetch(64'h8000_0000_0000_1000, 0);
        do_fetch(64'h0000_0040_0000_2000, 0);

        // sflush drops the cached page
        @(negedge clk);
        sflush = 1'b1;
        @(negedge clk);
        sflush = 1'b0;
        do_fetch(make_vaddr(27'h00100, 12'h020), 1);

        // more pages than entries, twice over
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 2 * TLB_ENTRIES + 3; i++) begin
                do_fetch(make_vaddr(27'h02000 + 27'(i * 3), 12'($random(seed))), 2);
            end
        end

        cycles = 0;
        while (exp_paddr_q.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_paddr_q.size() != 0) begin
            timeouts++;
            $display("%0d outputs were never delivered to the icache", exp_paddr_q.size());
        end

        $display("errors: value %0d, miss %0d, property %0d, timeout %0d",
                 value_errors, miss_errors, i_immu.i_immu_properties.fail_count, timeouts);
        if (value_errors == 0 && miss_errors == 0 && timeouts == 0
            && i_immu.i_immu_properties.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- src.f
src/immu_pkg.sv
src/immu_tlb.sv
src/immu_plru.sv
src/immu_walk_ctrl.sv
src/immu_resp.sv
src/immu.sv
tb/immu_properties.sv
tb/immu_tb.sv

//--- Bender.yml
package:
  name: immu

sources:
  - src/immu_pkg.sv
  - src/immu_tlb.sv
  - src/immu_plru.sv
  - src/immu_walk_ctrl.sv
  - src/immu_resp.sv
  - src/immu.sv
  - target: test
    files:
      - tb/immu_properties.sv
      - tb/immu_tb.sv
